//--- src/lb_fifo_cfg.svh
// Sizes for the loopback buffer. Both FIFO depths must be powers of two
// LB_START_THR must not exceed LB_SKID_DEPTH or long packets never start
`ifndef LB_FIFO_CFG_SVH
`define LB_FIFO_CFG_SVH

// Payload bits carried by one beat, sop and eop travel beside it
`define LB_DATA_W 32

// Address width of the dual-clock FIFO
// Five bits give 32 entries of buffering across the clock boundary
`define LB_FIFO_AW 5

// Entries in the read-side skid FIFO
`define LB_SKID_DEPTH 16

// Skid occupancy at which a packet may start before its eop is buffered
// Chosen so a slower writer still keeps up once the packet is running
`define LB_START_THR 8

`endif

//--- src/lb_pkt_pkg.sv
// Beat layout stored in both FIFOs, payload in the upper bits
`include "lb_fifo_cfg.svh"

package lb_pkt_pkg;

    // One stored beat
    // The eop bit sits at the bottom so it can be picked out cheaply
    typedef struct packed {
        logic [`LB_DATA_W-1:0] data;
        logic                  sop;
        logic                  eop;
    } lb_beat_t;

    // Read-side framing state
    // FRM_IN means a sop has left and the matching eop has not
    typedef enum logic {
        FRM_IDLE = 1'b0,
        FRM_IN   = 1'b1
    } lb_frame_e;

endpackage

//--- src/lb_stat_pkg.sv
// Sticky error flags, both reported in the read clock domain
package lb_stat_pkg;

    // Number of error flags kept by the top level
    localparam int LB_ERR_N = 2;

    // Bit position of each flag inside lb_err_t
    typedef enum logic [0:0] {
        ERR_WR_DROP     = 1'b0,
        ERR_RD_UNDERRUN = 1'b1
    } lb_err_idx_e;

    // Flag set, indexed with lb_err_idx_e
    typedef logic [LB_ERR_N-1:0] lb_err_t;

endpackage

//--- src/lb_async_fifo.sv
// Read side reports empty for 8 read cycles after reset while the reset reaches the
// write domain, so the write clock must not be more than about twice as slow as read
`timescale 1ns/1ns
`include "lb_fifo_cfg.svh"

module lb_async_fifo (
    input  logic                 i_clk_w,
    input  logic                 i_clk_r,
    input  logic                 r_reset,
    input  logic                 i_wr,
    input  lb_pkt_pkg::lb_beat_t i_wr_beat,
    input  logic                 i_rd,
    output lb_pkt_pkg::lb_beat_t o_rd_beat,
    output logic                 o_full,
    output logic                 o_empty,
    input  logic                 i_drop,
    input  logic                 i_drop_clr,
    output logic                 o_drop_seen
);
    import lb_pkt_pkg::*;

    localparam int AW     = `LB_FIFO_AW;
    localparam int DEPTH  = 1 << AW;
    localparam int HOLD_W = 4;

    lb_beat_t          mem [DEPTH];
    lb_beat_t          mem_q;
    logic [1:0]        w_rst_sync;
    logic              w_reset;
    logic              wr_en;
    logic [AW:0]       wbin;
    logic [AW:0]       wgray;
    logic [AW:0]       wbin_next;
    logic [AW:0]       rgray_w1;
    logic [AW:0]       rgray_w2;
    logic              rd_en;
    logic [AW:0]       rbin;
    logic [AW:0]       rgray;
    logic [AW:0]       rbin_next;
    logic [AW:0]       wgray_r1;
    logic [AW:0]       wgray_r2;
    logic [HOLD_W-1:0] hold_cnt;
    logic              rst_hold;
    logic              w_drop_flag;
    logic [1:0]        w_clr_sync;
    logic [1:0]        r_drop_sync;

    // --------------------------------------------------
    // Write domain

    // The read-domain reset is sampled twice before it drives write-side state
    always_ff @(posedge i_clk_w)
    begin
        w_rst_sync <= {w_rst_sync[0], r_reset};
    end
    assign w_reset = w_rst_sync[1];

    // A write while full is ignored here, the caller counts it as a drop
    assign wr_en     = i_wr & ~o_full;
    assign wbin_next = wbin + (AW + 1)'(wr_en);

    always_ff @(posedge i_clk_w)
    begin
        if (w_reset)
        begin
            wbin     <= '0;
            wgray    <= '0;
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end
        else
        begin
            wbin     <= wbin_next;
            wgray    <= (wbin_next >> 1) ^ wbin_next;
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
        end
    end

    // Full when the pointers differ only in the two top gray bits
    assign o_full = (wgray == {~rgray_w2[AW:AW-1], rgray_w2[AW-2:0]});

    always_ff @(posedge i_clk_w)
    begin
        if (wr_en)
        begin
            mem[wbin[AW-1:0]] <= i_wr_beat;
        end
    end

    // Sticky drop flag, a new drop wins over a clear in the same cycle
    always_ff @(posedge i_clk_w)
    begin
        if (w_reset)
        begin
            w_clr_sync  <= '0;
            w_drop_flag <= 1'b0;
        end
        else
        begin
            w_clr_sync <= {w_clr_sync[0], i_drop_clr};
            if (i_drop)
                w_drop_flag <= 1'b1;
            else if (w_clr_sync[1])
                w_drop_flag <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Read domain

    assign rd_en     = i_rd & ~o_empty;
    assign rbin_next = rbin + (AW + 1)'(rd_en);

    always_ff @(posedge i_clk_r)
    begin
        if (r_reset)
        begin
            rbin        <= '0;
            rgray       <= '0;
            wgray_r1    <= '0;
            wgray_r2    <= '0;
            r_drop_sync <= '0;
        end
        else
        begin
            rbin        <= rbin_next;
            rgray       <= (rbin_next >> 1) ^ rbin_next;
            wgray_r1    <= wgray;
            wgray_r2    <= wgray_r1;
            r_drop_sync <= {r_drop_sync[0], w_drop_flag};
        end
    end

    // Counts out the startup window in which write-side pointers may still be unknown
    always_ff @(posedge i_clk_r)
    begin
        if (r_reset)
            hold_cnt <= '0;
        else if (rst_hold)
            hold_cnt <= hold_cnt + 1'b1;
    end
    assign rst_hold = ~hold_cnt[HOLD_W-1];

    assign o_empty     = rst_hold | (rgray == wgray_r2);
    assign o_drop_seen = r_drop_sync[1] & ~rst_hold;

    // Memory read then output register, the beat is at o_rd_beat two cycles after i_rd
    always_ff @(posedge i_clk_r)
    begin
        if (rd_en)
            mem_q <= mem[rbin[AW-1:0]];
        o_rd_beat <= mem_q;
    end

    a_no_wr_full: assert property (@(posedge i_clk_w) disable iff (w_reset)
        i_wr |-> !o_full)
        else $error("write into full dual-clock FIFO");

    a_no_rd_empty: assert property (@(posedge i_clk_r) disable iff (r_reset)
        i_rd |-> !o_empty)
        else $error("read from empty dual-clock FIFO");

endmodule

//--- src/lb_skid_fifo.sv
// Head beat is always on o_beat, so a pop takes it in the same cycle
`timescale 1ns/1ns
`include "lb_fifo_cfg.svh"

module lb_skid_fifo (
    input  logic                             i_clk_r,
    input  logic                             r_reset,
    input  logic                             i_push,
    input  lb_pkt_pkg::lb_beat_t             i_beat,
    input  logic                             i_pop,
    output lb_pkt_pkg::lb_beat_t             o_beat,
    output logic                             o_empty,
    output logic [$clog2(`LB_SKID_DEPTH):0]  o_count,
    output logic                             o_eop_held
);
    import lb_pkt_pkg::*;

    localparam int DEPTH = `LB_SKID_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    lb_beat_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   eop_cnt;
    logic          push_eop;
    logic          pop_eop;

    // Register array, no reset on the payload
    always_ff @(posedge i_clk_r)
    begin
        if (i_push)
            mem[wr_ptr] <= i_beat;
    end

    assign o_beat  = mem[rd_ptr];
    assign o_empty = (o_count == '0);

    // eop beats entering and leaving, used to tell a fully buffered packet
    assign push_eop = i_push & i_beat.eop;
    assign pop_eop  = i_pop & o_beat.eop;

    always_ff @(posedge i_clk_r)
    begin
        if (r_reset)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
            eop_cnt <= '0;
        end
        else
        begin
            if (i_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (i_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Push and pop in one cycle leave the counts unchanged
            o_count <= o_count + (PW + 1)'(i_push) - (PW + 1)'(i_pop);
            eop_cnt <= eop_cnt + (PW + 1)'(push_eop) - (PW + 1)'(pop_eop);
        end
    end

    assign o_eop_held = (eop_cnt != '0);

    a_no_push_full: assert property (@(posedge i_clk_r) disable iff (r_reset)
        i_push |-> (o_count < (PW + 1)'(DEPTH)))
        else $error("push into full skid FIFO");

    a_no_pop_empty: assert property (@(posedge i_clk_r) disable iff (r_reset)
        i_pop |-> !o_empty)
        else $error("pop from empty skid FIFO");

endmodule

//--- src/lb_loopback_fifo.sv
// The source has no back-pressure, beats offered while the FIFO is full are lost and flagged
// i_stat_clr must stay high 4 read cycles to also clear the write-side drop flag
`timescale 1ns/1ns
`include "lb_fifo_cfg.svh"

module lb_loopback_fifo (
    input  logic                  i_clk_w,
    input  logic                  i_clk_r,
    input  logic                  r_reset,
    input  logic                  i_valid,
    input  logic [`LB_DATA_W-1:0] i_data,
    input  logic                  i_sop,
    input  logic                  i_eop,
    input  logic                  i_read_req,
    input  logic                  i_stat_clr,
    output logic                  o_valid,
    output logic [`LB_DATA_W-1:0] o_data,
    output logic                  o_sop,
    output logic                  o_eop,
    output logic                  o_wr_drop_err,
    output logic                  o_rd_underrun_err
);
    import lb_pkt_pkg::*;
    import lb_stat_pkg::*;

    localparam int CW = $clog2(`LB_SKID_DEPTH) + 1;

    logic          in_valid_q;
    lb_beat_t      in_beat_q;
    logic          fifo_wr;
    logic          fifo_drop;
    logic          fifo_full;
    logic          fifo_empty;
    logic          fifo_rd;
    lb_beat_t      fifo_beat;
    logic          rd_v1;
    logic          rd_v2;
    logic [CW-1:0] fill_sum;
    lb_beat_t      skid_head;
    logic          skid_empty;
    logic [CW-1:0] skid_count;
    logic          skid_eop_held;
    logic          skid_pop;
    lb_frame_e     frm_state;
    logic          drop_seen;
    logic          underrun_q;
    lb_err_t       err_flags;

    // --------------------------------------------------
    // Write side

    // Input register follows the source every cycle
    always_ff @(posedge i_clk_w)
    begin
        in_valid_q <= i_valid;
        in_beat_q  <= '{data: i_data, sop: i_sop, eop: i_eop};
    end

    assign fifo_wr   = in_valid_q & ~fifo_full;
    assign fifo_drop = in_valid_q & fifo_full;

    lb_async_fifo u_async_fifo (
        .i_clk_w     (i_clk_w),
        .i_clk_r     (i_clk_r),
        .r_reset     (r_reset),
        .i_wr        (fifo_wr),
        .i_wr_beat   (in_beat_q),
        .i_rd        (fifo_rd),
        .o_rd_beat   (fifo_beat),
        .o_full      (fifo_full),
        .o_empty     (fifo_empty),
        .i_drop      (fifo_drop),
        .i_drop_clr  (i_stat_clr),
        .o_drop_seen (drop_seen)
    );

    // --------------------------------------------------
    // Feed from the dual-clock FIFO into the skid

    // Reads still in the two-cycle pipe already own a skid slot
    assign fill_sum = skid_count + CW'(rd_v1) + CW'(rd_v2);
    assign fifo_rd  = ~fifo_empty & (fill_sum < CW'(`LB_SKID_DEPTH));

    always_ff @(posedge i_clk_r)
    begin
        if (r_reset)
        begin
            rd_v1 <= 1'b0;
            rd_v2 <= 1'b0;
        end
        else
        begin
            rd_v1 <= fifo_rd;
            rd_v2 <= rd_v1;
        end
    end

    lb_skid_fifo u_skid_fifo (
        .i_clk_r    (i_clk_r),
        .r_reset    (r_reset),
        .i_push     (rd_v2),
        .i_beat     (fifo_beat),
        .i_pop      (skid_pop),
        .o_beat     (skid_head),
        .o_empty    (skid_empty),
        .o_count    (skid_count),
        .o_eop_held (skid_eop_held)
    );

    // --------------------------------------------------
    // Read side

    // Inside a packet every request is served, a new packet waits for the
    // threshold or for its own eop to be buffered so it runs without gaps
    assign skid_pop = i_read_req & ~skid_empty &
                      ((frm_state == FRM_IN) | skid_eop_held |
                       (skid_count >= CW'(`LB_START_THR)));

    assign o_valid = skid_pop;
    assign o_data  = skid_head.data;
    assign o_sop   = skid_head.sop;
    assign o_eop   = skid_head.eop;

    always_ff @(posedge i_clk_r)
    begin
        if (r_reset)
            frm_state <= FRM_IDLE;
        else if (skid_pop)
        begin
            if (skid_head.eop)
                frm_state <= FRM_IDLE;
            else if (skid_head.sop)
                frm_state <= FRM_IN;
        end
    end

    // Sink asked for data in mid packet and nothing was there
    always_ff @(posedge i_clk_r)
    begin
        if (r_reset | i_stat_clr)
            underrun_q <= 1'b0;
        else if (i_read_req & (frm_state == FRM_IN) & skid_empty)
            underrun_q <= 1'b1;
    end

    always_comb
    begin
        err_flags                  = '0;
        err_flags[ERR_WR_DROP]     = drop_seen;
        err_flags[ERR_RD_UNDERRUN] = underrun_q;
    end

    assign o_wr_drop_err     = err_flags[ERR_WR_DROP];
    assign o_rd_underrun_err = err_flags[ERR_RD_UNDERRUN];

    a_idle_starts_sop: assert property (@(posedge i_clk_r) disable iff (r_reset)
        (o_valid && frm_state == FRM_IDLE) |-> o_sop)
        else $error("beat left outside a packet without sop");

endmodule

//--- verif/tb_lb_loopback_fifo.sv
// Table-driven testbench that runs one entry at a time and lets it drain before the next
// Write clock 6 ns and read clock 4 ns, the ratio that the dual-clock FIFO startup allows
`timescale 1ns/1ns
`include "lb_fifo_cfg.svh"

module tb_lb_loopback_fifo;

    localparam logic [1:0] REQ_HIGH = 2'd0;
    localparam logic [1:0] REQ_RAND = 2'd1;
    localparam logic [1:0] REQ_LOW  = 2'd2;
    localparam int         N_ENTRY  = 9;
    localparam logic [7:0] KEEP_ALL = 8'd255;
    // Beats that fit while the sink is stalled, dual-clock FIFO plus skid
    localparam logic [7:0] KEEP_FULL = 8'((1 << `LB_FIFO_AW) + `LB_SKID_DEPTH);

    // One table row, pkts packets of len beats each
    typedef struct packed {
        logic [7:0]  len;
        logic [7:0]  pkts;
        logic [31:0] first;
        logic [7:0]  pause_at;
        logic [7:0]  pause_len;
        logic [1:0]  req_mode;
        logic [7:0]  keep;
        logic        exp_drop;
        logic        exp_underrun;
    } entry_t;

    logic                  i_clk_w;
    logic                  i_clk_r;
    logic                  r_reset;
    logic                  i_valid;
    logic [`LB_DATA_W-1:0] i_data;
    logic                  i_sop;
    logic                  i_eop;
    logic                  i_read_req;
    logic                  i_stat_clr;
    logic                  o_valid;
    logic [`LB_DATA_W-1:0] o_data;
    logic                  o_sop;
    logic                  o_eop;
    logic                  o_wr_drop_err;
    logic                  o_rd_underrun_err;

    entry_t                tbl [N_ENTRY];
    logic [`LB_DATA_W+1:0] exp_q [$];
    logic [`LB_DATA_W+1:0] exp_b;
    logic [1:0]            req_mode;
    logic                  chk_gapless = 1'b0;
    logic                  in_pkt = 1'b0;
    integer                seed = 17549;
    int                    i;

    lb_loopback_fifo dut0 (
        .i_clk_w           (i_clk_w),
        .i_clk_r           (i_clk_r),
        .r_reset           (r_reset),
        .i_valid           (i_valid),
        .i_data            (i_data),
        .i_sop             (i_sop),
        .i_eop             (i_eop),
        .i_read_req        (i_read_req),
        .i_stat_clr        (i_stat_clr),
        .o_valid           (o_valid),
        .o_data            (o_data),
        .o_sop             (o_sop),
        .o_eop             (o_eop),
        .o_wr_drop_err     (o_wr_drop_err),
        .o_rd_underrun_err (o_rd_underrun_err)
    );

    initial
    begin
        i_clk_r = 1'b0;
        forever #2 i_clk_r = ~i_clk_r;
    end

    initial
    begin
        i_clk_w = 1'b0;
        forever #3 i_clk_w = ~i_clk_w;
    end

    // --------------------------------------------------
    // Error reporting

    task automatic halt_failed();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_value(input string sig, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        $display("error at %0t ns: %s expected %0h actual %0h", $time, sig, exp_v, act_v);
        halt_failed();
    endtask

    task automatic report_fault(input string what);
        $display("at %0t ns: %s", $time, what);
        halt_failed();
    endtask

    // --------------------------------------------------
    // Read side driver and scoreboard

    // Sink request follows the entry mode, random gaps drop about a quarter of cycles
    always @(posedge i_clk_r)
    begin
        #1;
        case (req_mode)
            REQ_HIGH: i_read_req = 1'b1;
            REQ_RAND: i_read_req = (($random(seed) & 3) != 0);
            default:  i_read_req = 1'b0;
        endcase
    end

    // Values seen at the edge are the ones settled during the previous cycle
    always @(posedge i_clk_r)
    begin
        if (!r_reset && o_valid)
        begin
            assert (exp_q.size() != 0)
            else report_fault("a beat left the DUT with no beat outstanding");
            exp_b = exp_q.pop_front();
            assert (o_data == exp_b[`LB_DATA_W+1:2])
            else report_value("o_data", exp_b[`LB_DATA_W+1:2], o_data);
            assert (o_sop == exp_b[1]) else report_value("o_sop", exp_b[1], o_sop);
            assert (o_eop == exp_b[0]) else report_value("o_eop", exp_b[0], o_eop);
            in_pkt = !o_eop;
        end
        else if (!r_reset)
        begin
            // Between sop and eop a requesting sink must get a beat every cycle
            assert (!(chk_gapless && in_pkt && i_read_req))
            else report_fault("o_valid went low inside a packet while i_read_req was high");
        end
    end

    // --------------------------------------------------
    // Stimulus and sequencing

    task automatic load_table();
        // len, pkts, first payload, pause after beat, pause cycles, request mode,
        // beats expected out, expected drop flag, expected underrun flag
        tbl[0] = '{8'd1,  8'd1,  32'h1000_0000, 8'd0,  8'd0,  REQ_HIGH, KEEP_ALL, 1'b0, 1'b0};
        tbl[1] = '{8'd3,  8'd2,  32'h2000_0000, 8'd0,  8'd0,  REQ_HIGH, KEEP_ALL, 1'b0, 1'b0};
        tbl[2] = '{8'd8,  8'd1,  32'h3000_0000, 8'd0,  8'd0,  REQ_HIGH, KEEP_ALL, 1'b0, 1'b0};
        tbl[3] = '{8'd20, 8'd1,  32'h4000_0000, 8'd0,  8'd0,  REQ_HIGH, KEEP_ALL, 1'b0, 1'b0};
        tbl[4] = '{8'd5,  8'd4,  32'h5000_0000, 8'd0,  8'd0,  REQ_RAND, KEEP_ALL, 1'b0, 1'b0};
        tbl[5] = '{8'd13, 8'd3,  32'h6000_0000, 8'd0,  8'd0,  REQ_RAND, KEEP_ALL, 1'b0, 1'b0};
        tbl[6] = '{8'd4,  8'd15, 32'h7000_0000, 8'd0,  8'd0,  REQ_LOW, KEEP_FULL, 1'b1, 1'b0};
        tbl[7] = '{8'd16, 8'd1,  32'h8000_0000, 8'd10, 8'd40, REQ_HIGH, KEEP_ALL, 1'b0, 1'b1};
        tbl[8] = '{8'd12, 8'd2,  32'h9000_0000, 8'd0,  8'd0,  REQ_HIGH, KEEP_ALL, 1'b0, 1'b0};
    endtask

    // Back-to-back beats on the write clock, beats past the keep count are expected lost
    task automatic send_packets(input entry_t e);
        int k;
        int p;
        int b;
        k = 0;
        for (p = 0; p < e.pkts; p++)
        begin
            for (b = 0; b < e.len; b++)
            begin
                @(posedge i_clk_w);
                #1;
                i_valid = 1'b1;
                i_data  = e.first + k;
                i_sop   = (b == 0);
                i_eop   = (b == e.len - 1);
                if (k < e.keep)
                    exp_q.push_back({i_data, i_sop, i_eop});
                k++;
                if (b + 1 == e.pause_at)
                begin
                    repeat (e.pause_len)
                    begin
                        @(posedge i_clk_w);
                        #1;
                        i_valid = 1'b0;
                    end
                end
            end
        end
        @(posedge i_clk_w);
        #1;
        i_valid = 1'b0;
    endtask

    task automatic wait_drop_set(input int limit);
        int n;
        n = 0;
        while (!o_wr_drop_err && n < limit)
        begin
            @(posedge i_clk_r);
            #1;
            n++;
        end
        assert (o_wr_drop_err) else report_fault("timeout waiting for o_wr_drop_err to set");
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit)
        begin
            @(posedge i_clk_r);
            #1;
            n++;
        end
        assert (exp_q.size() == 0) else report_fault("timeout waiting for beats to leave");
    endtask

    // The clear level is held 4 read cycles so it also reaches the write domain
    task automatic clear_flags(input int limit);
        int n;
        @(posedge i_clk_r);
        #1;
        i_stat_clr = 1'b1;
        repeat (4) @(posedge i_clk_r);
        #1;
        i_stat_clr = 1'b0;
        n = 0;
        while ((o_wr_drop_err || o_rd_underrun_err) && n < limit)
        begin
            @(posedge i_clk_r);
            #1;
            n++;
        end
        assert (!o_wr_drop_err && !o_rd_underrun_err)
        else report_fault("timeout waiting for the error flags to clear");
    endtask

    task automatic run_entry(input entry_t e);
        chk_gapless = !e.exp_underrun;
        req_mode    = e.req_mode;
        send_packets(e);
        // A stalled sink is released only once the overflow has been flagged
        if (e.req_mode == REQ_LOW)
        begin
            wait_drop_set(100);
            req_mode = REQ_HIGH;
        end
        wait_drained(2000);
        // Quiet window in which any extra beat would hit an empty scoreboard
        repeat (20) @(posedge i_clk_r);
        #1;
        assert (o_wr_drop_err == e.exp_drop)
        else report_value("o_wr_drop_err", e.exp_drop, o_wr_drop_err);
        assert (o_rd_underrun_err == e.exp_underrun)
        else report_value("o_rd_underrun_err", e.exp_underrun, o_rd_underrun_err);
        clear_flags(30);
    endtask

    initial
    begin
        r_reset    = 1'b1;
        i_valid    = 1'b0;
        i_data     = '0;
        i_sop      = 1'b0;
        i_eop      = 1'b0;
        i_read_req = 1'b0;
        i_stat_clr = 1'b0;
        req_mode   = REQ_LOW;
        load_table();
        repeat (2) @(posedge i_clk_r);
        #1;
        r_reset = 1'b0;
        // The FIFO reports empty while its reset reaches the write domain
        repeat (12) @(posedge i_clk_r);
        for (i = 0; i < N_ENTRY; i++)
            run_entry(tbl[i]);
        $display("sim passed");
        $finish;
    end

endmodule

//--- lb_loopback_fifo.f
+incdir+src
src/lb_pkt_pkg.sv
src/lb_stat_pkg.sv
src/lb_async_fifo.sv
src/lb_skid_fifo.sv
src/lb_loopback_fifo.sv
verif/tb_lb_loopback_fifo.sv

//--- Bender.yml
package:
  name: lb_loopback_fifo

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/lb_pkt_pkg.sv
      - src/lb_stat_pkg.sv
      - src/lb_async_fifo.sv
      - src/lb_skid_fifo.sv
      - src/lb_loopback_fifo.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_lb_loopback_fifo.sv
